// File: Bender.yml
package:
  name: axi_led

sources:
  - common/axi_led_pkg.sv
  - design/cmd_fifo.sv
  - bus/bus_master.sv
  - bus/axi_slave_router.sv
  - design/led_reg_bank.sv
  - design/axi_led_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/axi_led_tb.sv

// File: all.f
+incdir+dv
common/axi_led_pkg.sv
design/cmd_fifo.sv
bus/bus_master.sv
bus/axi_slave_router.sv
design/led_reg_bank.sv
design/axi_led_top.sv
dv/axi_led_tb.sv

// File: bus/axi_slave_router.sv
module axi_slave_router (
    input  logic                                 bus_clk,
    input  logic                                 rst,
    input  logic                                 aw_valid,
    input  logic [axi_led_pkg::ADDR_W-1:0]       aw_addr,
    input  logic                                 w_valid,
    input  logic [axi_led_pkg::DATA_W-1:0]       w_data,
    input  logic [axi_led_pkg::STRB_W-1:0]       w_strb,
    input  logic                                 b_ready,
    input  logic                                 ar_valid,
    input  logic [axi_led_pkg::ADDR_W-1:0]       ar_addr,
    input  logic                                 r_ready,
    input  logic [axi_led_pkg::DATA_W-1:0]       reg_rdata,
    output logic                                 aw_ready,
    output logic                                 w_ready,
    output logic                                 b_valid,
    output axi_led_pkg::bus_resp_e               b_resp,
    output logic                                 ar_ready,
    output logic                                 r_valid,
    output logic [axi_led_pkg::DATA_W-1:0]       r_data,
    output axi_led_pkg::bus_resp_e               r_resp,
    output logic                                 reg_wr,
    output logic                                 reg_rd,
    output logic [axi_led_pkg::LED_IDX_W-1:0]    reg_idx,
    output logic [axi_led_pkg::DATA_W-1:0]       reg_wdata,
    output logic [axi_led_pkg::STRB_W-1:0]       reg_strb
);
    import axi_led_pkg::*;

    logic aw_hit;
    logic ar_hit;
    logic wr_fire;
    logic rd_fire;
    logic busy;

    assign aw_hit = (aw_addr[ADDR_W-1 -: REGION_W] == REGION_LED);
    assign ar_hit = (ar_addr[ADDR_W-1 -: REGION_W] == REGION_LED);

    assign wr_fire = aw_valid && aw_ready && w_valid && w_ready;
    assign rd_fire = ar_valid && ar_ready;
    assign busy    = aw_ready || ar_ready || b_valid || r_valid;   // one transfer at a time

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            ar_ready <= 1'b0;
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            aw_ready <= aw_valid && w_valid && !busy;
            w_ready  <= aw_valid && w_valid && !busy;
            ar_ready <= ar_valid && !(aw_valid && w_valid) && !busy;   // writes first
            if (wr_fire)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
            if (rd_fire)
                r_valid <= 1'b1;
            else if (r_ready)
                r_valid <= 1'b0;
        end
    end

    // unmapped regions fall through to the decode error responder
    always_ff @(posedge bus_clk) begin
        if (wr_fire)
            b_resp <= aw_hit ? RESP_OKAY : RESP_DECERR;
        if (rd_fire) begin
            r_resp <= ar_hit ? RESP_OKAY : RESP_DECERR;
            r_data <= ar_hit ? reg_rdata : '0;
        end
    end

    assign reg_wr    = wr_fire && aw_hit;
    assign reg_rd    = rd_fire && ar_hit;
    assign reg_idx   = wr_fire ? aw_addr[LED_IDX_LSB +: LED_IDX_W]
                               : ar_addr[LED_IDX_LSB +: LED_IDX_W];
    assign reg_wdata = w_data;
    assign reg_strb  = w_strb;

    a_one_resp: assert property (@(posedge bus_clk) disable iff (rst) !(b_valid && r_valid));

endmodule

// File: bus/bus_master.sv
module bus_master (
    input  logic                              bus_clk,
    input  logic                              rst,
    input  logic                              empty,
    input  axi_led_pkg::bus_op_e              head_op,
    input  logic [axi_led_pkg::ADDR_W-1:0]    head_addr,
    input  logic [axi_led_pkg::DATA_W-1:0]    head_wdata,
    input  logic [axi_led_pkg::STRB_W-1:0]    head_strb,
    input  logic                              aw_ready,
    input  logic                              w_ready,
    input  logic                              b_valid,
    input  axi_led_pkg::bus_resp_e            b_resp,
    input  logic                              ar_ready,
    input  logic                              r_valid,
    input  logic [axi_led_pkg::DATA_W-1:0]    r_data,
    input  axi_led_pkg::bus_resp_e            r_resp,
    output logic                              pop,
    output logic                              aw_valid,
    output logic [axi_led_pkg::ADDR_W-1:0]    aw_addr,
    output logic                              w_valid,
    output logic [axi_led_pkg::DATA_W-1:0]    w_data,
    output logic [axi_led_pkg::STRB_W-1:0]    w_strb,
    output logic                              b_ready,
    output logic                              ar_valid,
    output logic [axi_led_pkg::ADDR_W-1:0]    ar_addr,
    output logic                              r_ready,
    output logic                              rsp_valid,
    output axi_led_pkg::bus_op_e              rsp_op,
    output logic [axi_led_pkg::DATA_W-1:0]    rsp_rdata,
    output axi_led_pkg::bus_resp_e            rsp_resp
);
    import axi_led_pkg::*;

    master_state_e state;
    logic          aw_done;
    logic          w_done;
    logic          b_fire;
    logic          r_fire;

    assign pop     = (state == MS_IDLE) && !empty;
    assign b_ready = (state == MS_WRESP);
    assign r_ready = (state == MS_RDATA);

    // channel finished when its valid is already gone or it transfers now
    assign aw_done = !aw_valid || aw_ready;
    assign w_done  = !w_valid || w_ready;
    assign b_fire  = b_valid && b_ready;
    assign r_fire  = r_valid && r_ready;

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            state     <= MS_IDLE;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
            ar_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                MS_IDLE: begin
                    if (pop) begin
                        if (head_op == OP_WRITE) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= MS_WRITE;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= MS_READ;
                        end
                    end
                end
                MS_WRITE: begin
                    if (aw_ready)
                        aw_valid <= 1'b0;
                    if (w_ready)
                        w_valid <= 1'b0;
                    if (aw_done && w_done)
                        state <= MS_WRESP;
                end
                MS_WRESP: begin
                    if (b_fire) begin
                        rsp_valid <= 1'b1;
                        state     <= MS_IDLE;
                    end
                end
                MS_READ: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        state    <= MS_RDATA;
                    end
                end
                MS_RDATA: begin
                    if (r_fire) begin
                        rsp_valid <= 1'b1;
                        state     <= MS_IDLE;
                    end
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    // command payload latched at pop, response at completion
    always_ff @(posedge bus_clk) begin
        if (pop) begin
            aw_addr <= head_addr;
            ar_addr <= head_addr;
            w_data  <= head_wdata;
            w_strb  <= head_strb;
            rsp_op  <= head_op;
        end
        if (b_fire) begin
            rsp_resp  <= b_resp;
            rsp_rdata <= '0;   // writes carry no data
        end
        if (r_fire) begin
            rsp_resp  <= r_resp;
            rsp_rdata <= (r_resp == RESP_OKAY) ? r_data : '0;
        end
    end

    a_aw_hold: assert property (@(posedge bus_clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));

    a_ar_hold: assert property (@(posedge bus_clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid);

endmodule

// File: common/axi_led_pkg.sv
package axi_led_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // region is the top address nibble
    localparam int REGION_W = 4;
    localparam logic [REGION_W-1:0] REGION_LED = 4'd2;

    // led register bank, word index in addr[3:2]
    localparam int LED_REGS = 4;
    localparam int LED_IDX_W = $clog2(LED_REGS);
    localparam int LED_IDX_LSB = 2;
    localparam int LED_W = 4;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11   // AXI encoding
    } bus_resp_e;

    typedef enum logic [2:0] {
        MS_IDLE  = 3'd0,
        MS_WRITE = 3'd1,
        MS_WRESP = 3'd2,
        MS_READ  = 3'd3,
        MS_RDATA = 3'd4
    } master_state_e;

endpackage

// File: design/axi_led_top.sv
module axi_led_top #(
    parameter int CMD_FIFO_DEPTH = 4
) (
    input  logic                              bus_clk,
    input  logic                              rst,
    input  logic                              cmd_valid,
    input  axi_led_pkg::bus_op_e              cmd_op,
    input  logic [axi_led_pkg::ADDR_W-1:0]    cmd_addr,
    input  logic [axi_led_pkg::DATA_W-1:0]    cmd_wdata,
    input  logic [axi_led_pkg::STRB_W-1:0]    cmd_strb,
    output logic                              cmd_overflow,
    output logic                              rsp_valid,
    output axi_led_pkg::bus_op_e              rsp_op,
    output logic [axi_led_pkg::DATA_W-1:0]    rsp_rdata,
    output axi_led_pkg::bus_resp_e            rsp_resp,
    output logic [axi_led_pkg::LED_W-1:0]     led
);
    import axi_led_pkg::*;

    // queue to master
    logic              pop;
    logic              empty;
    bus_op_e           head_op;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_wdata;
    logic [STRB_W-1:0] head_strb;

    // master to router
    logic              aw_valid, aw_ready;
    logic [ADDR_W-1:0] aw_addr;
    logic              w_valid, w_ready;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    logic              b_valid, b_ready;
    bus_resp_e         b_resp;
    logic              ar_valid, ar_ready;
    logic [ADDR_W-1:0] ar_addr;
    logic              r_valid, r_ready;
    logic [DATA_W-1:0] r_data;
    bus_resp_e         r_resp;

    // router to register bank
    logic                 reg_wr;
    logic                 reg_rd;
    logic [LED_IDX_W-1:0] reg_idx;
    logic [DATA_W-1:0]    reg_wdata;
    logic [STRB_W-1:0]    reg_strb;
    logic [DATA_W-1:0]    reg_rdata;

    cmd_fifo #(
        .DEPTH (CMD_FIFO_DEPTH)
    ) cmd_fifo_inst (
        .push       (cmd_valid),
        .push_op    (cmd_op),
        .push_addr  (cmd_addr),
        .push_wdata (cmd_wdata),
        .push_strb  (cmd_strb),
        .overflow   (cmd_overflow),
        .*
    );

    bus_master bus_master_inst (.*);

    axi_slave_router axi_slave_router_inst (.*);

    led_reg_bank led_reg_bank_inst (.*);

endmodule

// File: design/cmd_fifo.sv
module cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                              bus_clk,
    input  logic                              rst,
    input  logic                              push,
    input  axi_led_pkg::bus_op_e              push_op,
    input  logic [axi_led_pkg::ADDR_W-1:0]    push_addr,
    input  logic [axi_led_pkg::DATA_W-1:0]    push_wdata,
    input  logic [axi_led_pkg::STRB_W-1:0]    push_strb,
    input  logic                              pop,
    output logic                              empty,
    output logic                              overflow,
    output axi_led_pkg::bus_op_e              head_op,
    output logic [axi_led_pkg::ADDR_W-1:0]    head_addr,
    output logic [axi_led_pkg::DATA_W-1:0]    head_wdata,
    output logic [axi_led_pkg::STRB_W-1:0]    head_strb
);
    import axi_led_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bus_op_e           mem_op    [DEPTH];
    logic [ADDR_W-1:0] mem_addr  [DEPTH];
    logic [DATA_W-1:0] mem_wdata [DEPTH];
    logic [STRB_W-1:0] mem_strb  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && (!full || pop);   // a pop frees the slot this cycle

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push)
                overflow <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge bus_clk) begin
        if (do_push) begin
            mem_op[wr_ptr]    <= push_op;
            mem_addr[wr_ptr]  <= push_addr;
            mem_wdata[wr_ptr] <= push_wdata;
            mem_strb[wr_ptr]  <= push_strb;
        end
    end

    assign head_op    = mem_op[rd_ptr];
    assign head_addr  = mem_addr[rd_ptr];
    assign head_wdata = mem_wdata[rd_ptr];
    assign head_strb  = mem_strb[rd_ptr];

    // master must look at empty before popping
    a_no_pop_empty: assert property (@(posedge bus_clk) disable iff (rst) pop |-> !empty);

endmodule

// File: design/led_reg_bank.sv
module led_reg_bank (
    input  logic                                 bus_clk,
    input  logic                                 rst,
    input  logic                                 reg_wr,
    input  logic                                 reg_rd,
    input  logic [axi_led_pkg::LED_IDX_W-1:0]    reg_idx,
    input  logic [axi_led_pkg::DATA_W-1:0]       reg_wdata,
    input  logic [axi_led_pkg::STRB_W-1:0]       reg_strb,
    output logic [axi_led_pkg::DATA_W-1:0]       reg_rdata,
    output logic [axi_led_pkg::LED_W-1:0]        led
);
    import axi_led_pkg::*;

    logic [DATA_W-1:0] regs [LED_REGS];

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (reg_wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (reg_strb[b])
                    regs[reg_idx][8*b +: 8] <= reg_wdata[8*b +: 8];   // byte lane
            end
        end
    end

    assign reg_rdata = regs[reg_idx];
    assign led       = regs[0][LED_W-1:0];   // pins follow reg 0

    // reg_idx is shared, so a read and a write in one cycle would collide
    a_no_rd_wr: assert property (@(posedge bus_clk) disable iff (rst) !(reg_wr && reg_rd));

endmodule

// File: dv/axi_led_checks.svh
`ifndef AXI_LED_CHECKS_SVH
`define AXI_LED_CHECKS_SVH

task automatic check_resp(input bus_resp_e got, input bus_resp_e exp, input string what);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0t: %s response %s, expected %s",
                           $time, what, got.name(), exp.name()));
endtask

task automatic check_op(input bus_op_e got, input bus_op_e exp, input string what);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0t: %s opcode %s, expected %s",
                           $time, what, got.name(), exp.name()));
endtask

task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0t: %s data 0x%08h, expected 0x%08h",
                           $time, what, got, exp));
endtask

task automatic check_led(input logic [LED_W-1:0] got, input logic [LED_W-1:0] exp,
                         input string what);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0t: %s pins %b, expected %b", $time, what, got, exp));
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

// next response from the monitor queue
task automatic wait_rsp(output rsp_t r);
    int cycles;
    cycles = 0;
    while (rsp_q.size() == 0) begin
        if (cycles >= RSP_TIMEOUT)
            fail_now($sformatf("Timeout at %0t: no response within %0d cycles",
                               $time, RSP_TIMEOUT));
        @(posedge bus_clk);
        cycles++;
    end
    r = rsp_q.pop_front();
endtask

// throw away responses until the bus has been quiet for a while
task automatic drain_rsp();
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < 20) begin
        if (cycles >= DRAIN_TIMEOUT)
            fail_now("The bus never went idle while draining responses");
        @(posedge bus_clk);
        cycles++;
        if (rsp_q.size() != 0) begin
            rsp_q.delete();
            quiet = 0;
        end else begin
            quiet++;
        end
    end
endtask

`endif

// File: dv/axi_led_tb.sv
module axi_led_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import axi_led_pkg::*;

    localparam int CMD_FIFO_DEPTH = 4;
    localparam int RSP_TIMEOUT    = 200;
    localparam int DRAIN_TIMEOUT  = 1000;

    typedef struct packed {
        bus_op_e           op;
        bus_resp_e         resp;
        logic [DATA_W-1:0] rdata;
    } rsp_t;

    logic              bus_clk = 1'b0;
    logic              rst;
    logic              cmd_valid;
    bus_op_e           cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic [STRB_W-1:0] cmd_strb;
    logic              cmd_overflow;
    logic              rsp_valid;
    bus_op_e           rsp_op;
    logic [DATA_W-1:0] rsp_rdata;
    bus_resp_e         rsp_resp;
    logic [LED_W-1:0]  led;

    rsp_t              rsp_q[$];
    logic [DATA_W-1:0] model [LED_REGS];   // expected register contents

    always #4 bus_clk = ~bus_clk;

    axi_led_top #(
        .CMD_FIFO_DEPTH (CMD_FIFO_DEPTH)
    ) axi_led_top_inst (.*);

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    `include "axi_led_checks.svh"

    function automatic rsp_t make_rsp(input bus_op_e op, input bus_resp_e resp,
                                      input logic [DATA_W-1:0] rdata);
        rsp_t r;
        r.op    = op;
        r.resp  = resp;
        r.rdata = rdata;
        return r;
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr(input int region, input int idx);
        logic [ADDR_W-1:0] a;
        a = '0;
        a[ADDR_W-1 -: REGION_W]     = region[REGION_W-1:0];
        a[LED_IDX_LSB +: LED_IDX_W] = idx[LED_IDX_W-1:0];
        return a;
    endfunction

    // byte mask from strobes, then merge
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
            input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] mask;
        for (int b = 0; b < STRB_W; b++)
            mask[8*b +: 8] = {8{strb[b]}};
        return (old & ~mask) | (wdata & mask);
    endfunction

    // sampled away from the active edge
    always @(negedge bus_clk) begin
        if (!rst && rsp_valid)
            rsp_q.push_back(make_rsp(rsp_op, rsp_resp, rsp_rdata));
    end

    task automatic drive_cmd(input bus_op_e op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        @(posedge bus_clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_wdata <= wdata;
        cmd_strb  <= strb;
    endtask

    task automatic release_cmd();
        @(posedge bus_clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic run_cmd(input bus_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                           output rsp_t r);
        drive_cmd(op, addr, wdata, strb);
        release_cmd();
        wait_rsp(r);
    endtask

    task automatic expect_rsp(input rsp_t got, input rsp_t exp, input string what);
        check_op(got.op, exp.op, what);
        check_resp(got.resp, exp.resp, what);
        check_data(got.rdata, exp.rdata, what);
    endtask

    task automatic write_reg(input int idx, input logic [DATA_W-1:0] val,
                             input logic [STRB_W-1:0] strb);
        rsp_t r;
        run_cmd(OP_WRITE, reg_addr(REGION_LED, idx), val, strb, r);
        model[idx] = merge_bytes(model[idx], val, strb);
        expect_rsp(r, make_rsp(OP_WRITE, RESP_OKAY, '0), $sformatf("write reg %0d", idx));
    endtask

    task automatic read_reg(input int idx);
        rsp_t r;
        run_cmd(OP_READ, reg_addr(REGION_LED, idx), '0, '0, r);
        expect_rsp(r, make_rsp(OP_READ, RESP_OKAY, model[idx]), $sformatf("read reg %0d", idx));
    endtask

    task automatic test_reset();
        @(negedge bus_clk);
        check_led(led, '0, "led after reset");
        check_flag(cmd_overflow, 1'b0, "overflow after reset");
        for (int i = 0; i < LED_REGS; i++)
            read_reg(i);
    endtask

    task automatic test_write_read();
        int                idx;
        logic [DATA_W-1:0] val;
        rsp_t              r;
        idx = $urandom_range(LED_REGS - 1);
        val = $urandom;
        write_reg(idx, val, '1);
        run_cmd(OP_READ, reg_addr(REGION_LED, idx), '0, '0, r);
        expect_rsp(r, make_rsp(OP_READ, RESP_OKAY, val), "read back full write");
    endtask

    task automatic test_byte_strobes();
        for (int i = 0; i < 10; i++) begin
            write_reg($urandom_range(LED_REGS - 1), $urandom, $urandom_range(15));
            read_reg($urandom_range(LED_REGS - 1));
        end
        for (int i = 0; i < LED_REGS; i++)
            read_reg(i);
    endtask

    task automatic test_led_pins();
        for (int i = 0; i < 4; i++) begin
            write_reg(0, $urandom, '1);
            @(negedge bus_clk);
            check_led(led, model[0][LED_W-1:0], "led after full write");
        end
        write_reg(0, $urandom, 4'b1110);   // byte 0 untouched
        @(negedge bus_clk);
        check_led(led, model[0][LED_W-1:0], "led after upper byte write");
    endtask

    task automatic test_unmapped();
        int   regions[3] = '{0, 1, 3};
        rsp_t r;
        for (int i = 0; i < 3; i++) begin
            run_cmd(OP_WRITE, reg_addr(regions[i], i), $urandom, '1, r);
            expect_rsp(r, make_rsp(OP_WRITE, RESP_DECERR, '0),
                       $sformatf("write region %0d", regions[i]));
            run_cmd(OP_READ, reg_addr(regions[i], i), '0, '0, r);
            expect_rsp(r, make_rsp(OP_READ, RESP_DECERR, '0),
                       $sformatf("read region %0d", regions[i]));
        end
        for (int i = 0; i < LED_REGS; i++)
            read_reg(i);
    endtask

    task automatic test_queued();
        rsp_t              exp_q[$];
        rsp_t              r;
        logic [DATA_W-1:0] v0;
        logic [DATA_W-1:0] v1;
        v0 = $urandom;
        v1 = $urandom;
        drive_cmd(OP_WRITE, reg_addr(REGION_LED, 1), v0, '1);
        drive_cmd(OP_WRITE, reg_addr(REGION_LED, 2), v1, 4'b0011);
        drive_cmd(OP_READ, reg_addr(REGION_LED, 1), '0, '0);
        drive_cmd(OP_READ, reg_addr(REGION_LED, 2), '0, '0);
        drive_cmd(OP_READ, reg_addr(3, 0), '0, '0);
        release_cmd();
        model[1] = merge_bytes(model[1], v0, '1);
        model[2] = merge_bytes(model[2], v1, 4'b0011);
        exp_q.push_back(make_rsp(OP_WRITE, RESP_OKAY, '0));
        exp_q.push_back(make_rsp(OP_WRITE, RESP_OKAY, '0));
        exp_q.push_back(make_rsp(OP_READ, RESP_OKAY, model[1]));
        exp_q.push_back(make_rsp(OP_READ, RESP_OKAY, model[2]));
        exp_q.push_back(make_rsp(OP_READ, RESP_DECERR, '0));
        for (int i = 0; i < 5; i++) begin
            wait_rsp(r);
            expect_rsp(r, exp_q[i], $sformatf("queued command %0d", i));
        end
        @(negedge bus_clk);
        check_flag(cmd_overflow, 1'b0, "overflow after five commands");

        // far more than the queue can take
        for (int i = 0; i < 12; i++)
            drive_cmd(OP_READ, reg_addr(REGION_LED, 0), '0, '0);
        release_cmd();
        @(negedge bus_clk);
        check_flag(cmd_overflow, 1'b1, "overflow after burst of strobes");
        drain_rsp();
    endtask

    initial begin
        void'($urandom(67022));
        rst       <= 1'b1;
        cmd_valid <= 1'b0;
        cmd_op    <= OP_READ;
        cmd_addr  <= '0;
        cmd_wdata <= '0;
        cmd_strb  <= '0;
        model = '{default: '0};
        repeat (4) @(posedge bus_clk);
        rst <= 1'b0;

        test_reset();
        test_write_read();
        test_byte_strobes();
        test_led_pins();
        test_unmapped();
        test_queued();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
